// File: Makefile
# Verilator build and run for the shared AXI4-Lite register bank

TOP := tb_axil_shared_regs

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f axil_shared_regs.f --top-module $(TOP)

# The run passes only when the log holds the pass line
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test OK" sim.log

lint:
	verilator --lint-only --timing -Wall -f axil_shared_regs.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: axil_shared_regs.f
+incdir+hw
hw/rr_bank_pkg.sv
hw/br_rr_state_internal.sv
hw/br_arb_rr_internal.sv
hw/axil_port_stage.sv
hw/arb_stage.sv
hw/bank_stage.sv
hw/axil_shared_regs.sv
tb/tb_axil_shared_regs.sv

// File: hw/arb_stage.sv
`timescale 1ns/10ps

`include "rr_bank_cfg.svh"

module arb_stage (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic [`NUM_PORTS-1:0]                     req_valid,
  input  rr_bank_pkg::bank_req_t [`NUM_PORTS-1:0]   req,
  output logic [`NUM_PORTS-1:0]                     req_grant,
  output logic                                      bank_valid,
  output rr_bank_pkg::bank_req_t                    bank_req
);

  rr_bank_pkg::bank_req_t sel_req;

  // ----------------------------------------------------------------------
  // Round-robin pick
  // ----------------------------------------------------------------------

  // Zero-latency grant, priority moves whenever a port asks
  br_arb_rr_internal #(
    .NumRequesters(`NUM_PORTS)
  ) i_arb (
    .clk                   (clk),
    .rst                   (rst),
    .enable_priority_update(|req_valid),
    .request               (req_valid),
    .can_grant             (),
    .grant                 (req_grant)
  );

  // One-hot select of the winning request
  always_comb begin
    sel_req = '0;
    for (int i = 0; i < `NUM_PORTS; i++) begin
      if (req_grant[i]) begin
        sel_req = req[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Register toward the bank
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      bank_valid <= 1'b0;
    end else begin
      bank_valid <= |req_grant;
    end
  end

  // Payload only moves with a grant
  always_ff @(posedge clk) begin
    if (|req_grant) begin
      bank_req <= sel_req;
    end
  end

endmodule : arb_stage

// File: hw/axil_port_stage.sv
`timescale 1ns/10ps

`include "rr_bank_cfg.svh"

module axil_port_stage (
  input  logic                                clk,
  input  logic                                rst,
  // Write address
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [rr_bank_pkg::ADDR_W-1:0]      awaddr,
  // Write data
  input  logic                                wvalid,
  output logic                                wready,
  input  logic [`DATA_W-1:0]                  wdata,
  input  logic [rr_bank_pkg::STRB_W-1:0]      wstrb,
  // Write response
  output logic                                bvalid,
  input  logic                                bready,
  output rr_bank_pkg::resp_t                  bresp,
  // Read address
  input  logic                                arvalid,
  output logic                                arready,
  input  logic [rr_bank_pkg::ADDR_W-1:0]      araddr,
  // Read data
  output logic                                rvalid,
  input  logic                                rready,
  output logic [`DATA_W-1:0]                  rdata,
  output rr_bank_pkg::resp_t                  rresp,
  // Pipeline side
  input  rr_bank_pkg::port_idx_t              port_id,
  output logic                                req_valid,
  output rr_bank_pkg::bank_req_t              req,
  input  logic                                req_grant,
  input  logic                                rsp_valid,
  input  rr_bank_pkg::bank_rsp_t              rsp
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COLLECT,
    ST_REQ,
    ST_WAIT,
    ST_RESP
  } state_t;

  state_t                         state;
  logic                           have_aw;
  logic                           have_w;
  logic                           is_write;
  rr_bank_pkg::word_idx_t         word_q;
  logic [`DATA_W-1:0]             wdata_q;
  logic [rr_bank_pkg::STRB_W-1:0] wstrb_q;
  rr_bank_pkg::resp_t             resp_q;
  logic [`DATA_W-1:0]             rdata_q;
  logic                           aw_hs;
  logic                           w_hs;
  logic                           ar_hs;
  logic                           rsp_hit;
  logic                           done_hs;

  // ----------------------------------------------------------------------
  // Channel handshakes
  // ----------------------------------------------------------------------

  // Reads win over writes when both show up while idle
  assign arready = (state == ST_IDLE);
  // While collecting only the missing half is accepted
  assign awready = ((state == ST_IDLE) & ~arvalid) | ((state == ST_COLLECT) & ~have_aw);
  assign wready  = ((state == ST_IDLE) & ~arvalid) | ((state == ST_COLLECT) & ~have_w);

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign ar_hs = arvalid & arready;

  // Broadcast response taken only by the port it belongs to
  assign rsp_hit = rsp_valid & (rsp.port == port_id) & (state == ST_WAIT);

  assign bvalid  = (state == ST_RESP) & is_write;
  assign rvalid  = (state == ST_RESP) & ~is_write;
  assign bresp   = resp_q;
  assign rresp   = resp_q;
  assign rdata   = rdata_q;
  assign done_hs = (bvalid & bready) | (rvalid & rready);

  // Request toward arbitration
  assign req_valid = (state == ST_REQ);
  assign req = '{port: port_id, write: is_write, word: word_q, wdata: wdata_q, wstrb: wstrb_q};

  // ----------------------------------------------------------------------
  // Transaction FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      have_aw <= 1'b0;
      have_w  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ar_hs || (aw_hs && w_hs)) begin
            state <= ST_REQ;
          end else if (aw_hs || w_hs) begin
            // Hold the half that came first
            state   <= ST_COLLECT;
            have_aw <= aw_hs;
            have_w  <= w_hs;
          end
        end
        ST_COLLECT: begin
          // Any handshake here completes the pair
          if (aw_hs || w_hs) begin
            state   <= ST_REQ;
            have_aw <= 1'b0;
            have_w  <= 1'b0;
          end
        end
        ST_REQ: begin
          if (req_grant) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (rsp_hit) begin
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (done_hs) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Captured address, data and response
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      is_write <= 1'b0;
      word_q   <= araddr[9:2];
    end
    if (aw_hs) begin
      is_write <= 1'b1;
      word_q   <= awaddr[9:2];
    end
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (rsp_hit) begin
      resp_q  <= rsp.resp;
      rdata_q <= rsp.rdata;
    end
  end

  // A response tagged for this port only comes while it waits for one
  a_rsp_expected : assert property (@(posedge clk) disable iff (rst)
    rsp_valid && (rsp.port == port_id) |-> (state == ST_WAIT));

  // Bank answers with the same access kind this port issued
  a_rsp_kind : assert property (@(posedge clk) disable iff (rst)
    rsp_hit |-> (rsp.write == is_write));

endmodule : axil_port_stage

// File: hw/axil_shared_regs.sv
`timescale 1ns/10ps

`include "rr_bank_cfg.svh"

module axil_shared_regs (
  input  logic                                                clk,
  input  logic                                                rst,
  // Write address, one lane per master
  input  logic [`NUM_PORTS-1:0]                               awvalid,
  output logic [`NUM_PORTS-1:0]                               awready,
  input  logic [`NUM_PORTS-1:0][rr_bank_pkg::ADDR_W-1:0]      awaddr,
  // Write data
  input  logic [`NUM_PORTS-1:0]                               wvalid,
  output logic [`NUM_PORTS-1:0]                               wready,
  input  logic [`NUM_PORTS-1:0][`DATA_W-1:0]                  wdata,
  input  logic [`NUM_PORTS-1:0][rr_bank_pkg::STRB_W-1:0]      wstrb,
  // Write response
  output logic [`NUM_PORTS-1:0]                               bvalid,
  input  logic [`NUM_PORTS-1:0]                               bready,
  output rr_bank_pkg::resp_t [`NUM_PORTS-1:0]                 bresp,
  // Read address
  input  logic [`NUM_PORTS-1:0]                               arvalid,
  output logic [`NUM_PORTS-1:0]                               arready,
  input  logic [`NUM_PORTS-1:0][rr_bank_pkg::ADDR_W-1:0]      araddr,
  // Read data
  output logic [`NUM_PORTS-1:0]                               rvalid,
  input  logic [`NUM_PORTS-1:0]                               rready,
  output logic [`NUM_PORTS-1:0][`DATA_W-1:0]                  rdata,
  output rr_bank_pkg::resp_t [`NUM_PORTS-1:0]                 rresp
);

  logic [`NUM_PORTS-1:0]                    req_valid;
  rr_bank_pkg::bank_req_t [`NUM_PORTS-1:0]  req;
  logic [`NUM_PORTS-1:0]                    req_grant;
  logic                                     bank_valid;
  rr_bank_pkg::bank_req_t                   bank_req;
  logic                                     rsp_valid;
  rr_bank_pkg::bank_rsp_t                   rsp;

  // One capture stage per master, tagged by its lane index
  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_port
    axil_port_stage i_port (
      .clk      (clk),
      .rst      (rst),
      .awvalid  (awvalid[i]),
      .awready  (awready[i]),
      .awaddr   (awaddr[i]),
      .wvalid   (wvalid[i]),
      .wready   (wready[i]),
      .wdata    (wdata[i]),
      .wstrb    (wstrb[i]),
      .bvalid   (bvalid[i]),
      .bready   (bready[i]),
      .bresp    (bresp[i]),
      .arvalid  (arvalid[i]),
      .arready  (arready[i]),
      .araddr   (araddr[i]),
      .rvalid   (rvalid[i]),
      .rready   (rready[i]),
      .rdata    (rdata[i]),
      .rresp    (rresp[i]),
      .port_id  (rr_bank_pkg::port_idx_t'(i)),
      .req_valid(req_valid[i]),
      .req      (req[i]),
      .req_grant(req_grant[i]),
      .rsp_valid(rsp_valid),
      .rsp      (rsp)
    );
  end

  arb_stage i_arb_stage (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_grant (req_grant),
    .bank_valid(bank_valid),
    .bank_req  (bank_req)
  );

  // Response goes to every port, the matching one takes it
  bank_stage i_bank_stage (
    .clk       (clk),
    .rst       (rst),
    .bank_valid(bank_valid),
    .bank_req  (bank_req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule : axil_shared_regs

// File: hw/bank_stage.sv
`timescale 1ns/10ps

`include "rr_bank_cfg.svh"

module bank_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    bank_valid,
  input  rr_bank_pkg::bank_req_t  bank_req,
  output logic                    rsp_valid,
  output rr_bank_pkg::bank_rsp_t  rsp
);

  localparam int IDX_W = $clog2(`BANK_WORDS);

  logic [`DATA_W-1:0] mem [`BANK_WORDS];
  logic               in_range;
  logic [IDX_W-1:0]   idx;
  logic [`DATA_W-1:0] merged;

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------

  // Word index past the bank gets SLVERR
  assign in_range = int'(bank_req.word) < `BANK_WORDS;
  assign idx      = bank_req.word[IDX_W-1:0];

  // Old word with strobed bytes replaced
  always_comb begin
    merged = mem[idx];
    for (int b = 0; b < rr_bank_pkg::STRB_W; b++) begin
      if (bank_req.wstrb[b]) begin
        merged[8*b +: 8] = bank_req.wdata[8*b +: 8];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Register array
  // ----------------------------------------------------------------------

  // All words read zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `BANK_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (bank_valid && bank_req.write && in_range) begin
      mem[idx] <= merged;
    end
  end

  // ----------------------------------------------------------------------
  // Tagged response
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= bank_valid;
    end
  end

  // Out-of-range reads and all writes return zero data
  always_ff @(posedge clk) begin
    if (bank_valid) begin
      rsp.port  <= bank_req.port;
      rsp.write <= bank_req.write;
      rsp.resp  <= in_range ? rr_bank_pkg::RESP_OKAY : rr_bank_pkg::RESP_SLVERR;
      rsp.rdata <= (in_range && !bank_req.write) ? mem[idx] : '0;
    end
  end

  // One transaction per port in flight, so the two pipeline slots differ
  a_distinct_ports : assert property (@(posedge clk) disable iff (rst)
    rsp_valid && bank_valid |-> (rsp.port != bank_req.port));

endmodule : bank_stage

// File: hw/br_arb_rr_internal.sv
`timescale 1ns/10ps

module br_arb_rr_internal #(
  // At least 2 requesters
  parameter int NumRequesters = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enable_priority_update,
  input  logic [NumRequesters-1:0] request,
  output logic [NumRequesters-1:0] can_grant,
  output logic [NumRequesters-1:0] grant
);

  logic                                        update_priority;
  logic [NumRequesters-1:0]                    priority_mask;
  logic [NumRequesters-1:0]                    request_high;
  // Row i holds the requests that beat requester i
  logic [NumRequesters-1:0][NumRequesters-1:0] request_priority;

  // Rotate only when someone actually requests
  assign update_priority = enable_priority_update & (|request);

  br_rr_state_internal #(
    .NumRequesters(NumRequesters)
  ) i_rr_state (
    .clk            (clk),
    .rst            (rst),
    .update_priority(update_priority),
    .grant          (grant),
    .last_grant     (),
    .priority_mask  (priority_mask)
  );

  // ----------------------------------------------------------------------
  // Request priority matrix
  // ----------------------------------------------------------------------

  // Unmasked requests sit above the pointer and win first
  assign request_high = request & ~priority_mask;

  // Within a group the lower index wins
  // A high-group request always beats a masked one
  always_comb begin
    for (int i = 0; i < NumRequesters; i++) begin
      for (int j = 0; j < NumRequesters; j++) begin
        if (j < i) begin
          // Lower index wins only from the same group
          request_priority[i][j] = priority_mask[i] ? request[j] : request_high[j];
        end else if (j > i) begin
          // Higher index wins only if i is masked and j is not
          request_priority[i][j] = priority_mask[i] & request_high[j];
        end else begin
          request_priority[i][j] = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------

  // No stronger request anywhere in the row
  for (genvar i = 0; i < NumRequesters; i++) begin : gen_can_grant
    assign can_grant[i] = ~(|request_priority[i]);
  end

  // Same-cycle grant, no register on this path
  assign grant = request & can_grant;

  a_grant_onehot : assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant));

endmodule : br_arb_rr_internal

// File: hw/br_rr_state_internal.sv
`timescale 1ns/10ps

module br_rr_state_internal #(
  // At least 2 requesters
  parameter int NumRequesters = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     update_priority,
  input  logic [NumRequesters-1:0] grant,
  output logic [NumRequesters-1:0] last_grant,
  output logic [NumRequesters-1:0] priority_mask
);

  // Value after reset: top index looks like the last winner
  localparam logic [NumRequesters-1:0] LastGrantInit = {1'b1, {(NumRequesters - 1){1'b0}}};

  // ----------------------------------------------------------------------
  // Last grant register
  // ----------------------------------------------------------------------

  // Index 0 leads the first round
  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= LastGrantInit;
    end else if (update_priority) begin
      // Winner drops to lowest priority next cycle
      last_grant <= grant;
    end
  end

  // ----------------------------------------------------------------------
  // Priority mask
  // ----------------------------------------------------------------------

  // Bit i set when the last winner sits at index i or above
  // Set bits form the low-priority group after wraparound
  for (genvar i = 0; i < NumRequesters; i++) begin : gen_mask
    assign priority_mask[i] = |last_grant[NumRequesters-1:i];
  end

  // Priority only moves onto a requester that really won
  a_update_has_grant : assert property (@(posedge clk) disable iff (rst)
    update_priority |-> |grant);

endmodule : br_rr_state_internal

// File: hw/rr_bank_cfg.svh
`ifndef RR_BANK_CFG_SVH
`define RR_BANK_CFG_SVH

// Number of AXI4-Lite masters sharing the bank
`define NUM_PORTS 4

// Registers in the bank
`define BANK_WORDS 16

// Register and bus data width in bits
`define DATA_W 32

`endif

// File: hw/rr_bank_pkg.sv
package rr_bank_pkg;

  `include "rr_bank_cfg.svh"

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Port index needs at least one bit
  localparam int PORT_W = (`NUM_PORTS > 1) ? $clog2(`NUM_PORTS) : 1;
  localparam int ADDR_W = 32;
  // One strobe per byte lane
  localparam int STRB_W = `DATA_W / 8;

  typedef logic [PORT_W-1:0] port_idx_t;

  // Address bits 9:2, wide enough to see words past the bank
  typedef logic [7:0] word_idx_t;

  typedef logic [1:0] resp_t;

  // AXI response codes in use
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ----------------------------------------------------------------------
  // Pipeline payloads
  // ----------------------------------------------------------------------

  // Request from a port toward the bank
  typedef struct packed {
    port_idx_t           port;
    logic                write;
    word_idx_t           word;
    logic [`DATA_W-1:0]  wdata;
    logic [STRB_W-1:0]   wstrb;
  } bank_req_t;

  // Response broadcast back, tagged with the issuing port
  typedef struct packed {
    port_idx_t           port;
    logic                write;
    resp_t               resp;
    logic [`DATA_W-1:0]  rdata;
  } bank_rsp_t;

endpackage : rr_bank_pkg

// File: tb/axil_shared_regs_patterns.txt
// batch port op addr data strb exp_data exp_resp, all fields in hex
// op 0 read, 1 write, 2 read with ready held high for the fairness check
0 0 0 00000000 00000000 0 00000000 0
0 0 0 00000004 00000000 0 00000000 0
0 0 0 00000008 00000000 0 00000000 0
0 0 0 0000000c 00000000 0 00000000 0
0 1 0 00000010 00000000 0 00000000 0
0 1 0 00000014 00000000 0 00000000 0
0 1 0 00000018 00000000 0 00000000 0
0 1 0 0000001c 00000000 0 00000000 0
0 2 0 00000020 00000000 0 00000000 0
0 2 0 00000024 00000000 0 00000000 0
0 2 0 00000028 00000000 0 00000000 0
0 2 0 0000002c 00000000 0 00000000 0
0 3 0 00000030 00000000 0 00000000 0
0 3 0 00000034 00000000 0 00000000 0
0 3 0 00000038 00000000 0 00000000 0
0 3 0 0000003c 00000000 0 00000000 0
1 0 1 00000000 a5a50001 f 00000000 0
2 0 0 00000000 00000000 0 a5a50001 0
2 1 1 00000014 11223344 f 00000000 0
3 1 1 00000014 aabbccdd 5 00000000 0
4 1 0 00000014 00000000 0 11bb33dd 0
4 2 1 00000040 deadbeef f 00000000 2
4 3 0 000003fc 00000000 0 00000000 2
5 0 0 00000000 00000000 0 a5a50001 0
5 2 0 00000040 00000000 0 00000000 2
6 0 1 00000020 10000000 f 00000000 0
6 1 1 00000024 20000001 f 00000000 0
6 2 1 00000028 30000002 f 00000000 0
6 3 1 0000002c 40000003 f 00000000 0
7 0 0 0000002c 00000000 0 40000003 0
7 1 0 00000028 00000000 0 30000002 0
7 2 0 00000024 00000000 0 20000001 0
7 3 0 00000020 00000000 0 10000000 0
8 0 2 00000020 00000000 0 10000000 0
8 0 2 00000020 00000000 0 10000000 0
8 1 2 00000024 00000000 0 20000001 0
8 1 2 00000024 00000000 0 20000001 0
8 2 2 00000028 00000000 0 30000002 0
8 2 2 00000028 00000000 0 30000002 0
8 3 2 0000002c 00000000 0 40000003 0
8 3 2 0000002c 00000000 0 40000003 0

// File: tb/tb_axil_shared_regs.sv
`timescale 1ns/10ps

`include "rr_bank_cfg.svh"

module tb_axil_shared_regs;

  localparam int FIELDS    = 8;
  localparam int MAX_LINES = 64;
  localparam int TIMEOUT   = 200;
  localparam int STRB_W    = rr_bank_pkg::STRB_W;

  logic                               clk;
  logic                               rst;
  logic [`NUM_PORTS-1:0]              awvalid;
  logic [`NUM_PORTS-1:0]              awready;
  logic [`NUM_PORTS-1:0][31:0]        awaddr;
  logic [`NUM_PORTS-1:0]              wvalid;
  logic [`NUM_PORTS-1:0]              wready;
  logic [`NUM_PORTS-1:0][`DATA_W-1:0] wdata;
  logic [`NUM_PORTS-1:0][STRB_W-1:0]  wstrb;
  logic [`NUM_PORTS-1:0]              bvalid;
  logic [`NUM_PORTS-1:0]              bready;
  logic [`NUM_PORTS-1:0][1:0]         bresp;
  logic [`NUM_PORTS-1:0]              arvalid;
  logic [`NUM_PORTS-1:0]              arready;
  logic [`NUM_PORTS-1:0][31:0]        araddr;
  logic [`NUM_PORTS-1:0]              rvalid;
  logic [`NUM_PORTS-1:0]              rready;
  logic [`NUM_PORTS-1:0][`DATA_W-1:0] rdata;
  logic [`NUM_PORTS-1:0][1:0]         rresp;

  // Pattern memory with eight words per transaction
  logic [31:0] pat [FIELDS*MAX_LINES];
  int          num_lines;
  int          errors;
  int          tests;
  int          failed_tests;
  bit          timed_out;
  // Port that won arbitration last
  int          last_winner;
  // Ports in the order their responses arrived
  int          order [$];

  axil_shared_regs i_axil_shared_regs (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Checks and reporting
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, inout bit ok);
    if (actual !== expected) begin
      $display("FAIL %0t ns %s expected 0x%h actual 0x%h", $time, name, expected, actual);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic report_timeout(input int p, input string chan);
    $display("Port %0d got no %s handshake within %0d cycles", p, chan, TIMEOUT);
    errors++;
    timed_out = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // Per-port master
  // ----------------------------------------------------------------------

  task automatic run_transaction(input int p, input int n);
    logic [31:0] batch;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] strb;
    logic [31:0] exp_data;
    logic [31:0] exp_resp;
    bit          ok;
    bit          aw_done;
    bit          w_done;
    bit          aw_hs;
    bit          w_hs;
    bit          ar_hs;
    int          cnt;
    int          delay;
    batch    = pat[n*FIELDS];
    op       = pat[n*FIELDS+2];
    addr     = pat[n*FIELDS+3];
    data     = pat[n*FIELDS+4];
    strb     = pat[n*FIELDS+5];
    exp_data = pat[n*FIELDS+6];
    exp_resp = pat[n*FIELDS+7];
    ok       = 1'b1;
    cnt      = 0;
    @(posedge clk);
    if (op == 1) begin
      awvalid[p] <= 1'b1;
      awaddr[p]  <= addr;
      wvalid[p]  <= 1'b1;
      wdata[p]   <= data;
      wstrb[p]   <= strb[STRB_W-1:0];
      aw_done = 1'b0;
      w_done  = 1'b0;
      // AW and W may be taken in different cycles
      while (!(aw_done && w_done)) begin
        if (cnt == TIMEOUT) begin
          report_timeout(p, "write address or write data");
          return;
        end
        @(negedge clk);
        aw_hs = awvalid[p] && awready[p];
        w_hs  = wvalid[p] && wready[p];
        @(posedge clk);
        if (aw_hs) begin
          awvalid[p] <= 1'b0;
          aw_done = 1'b1;
        end
        if (w_hs) begin
          wvalid[p] <= 1'b0;
          w_done = 1'b1;
        end
        cnt++;
      end
    end else begin
      arvalid[p] <= 1'b1;
      araddr[p]  <= addr;
      // Fairness reads keep rready up from the start
      if (op == 2) begin
        rready[p] <= 1'b1;
      end
      ar_hs = 1'b0;
      while (!ar_hs) begin
        if (cnt == TIMEOUT) begin
          report_timeout(p, "read address");
          return;
        end
        @(negedge clk);
        ar_hs = arvalid[p] && arready[p];
        @(posedge clk);
        cnt++;
      end
      arvalid[p] <= 1'b0;
    end

    // Response wait sampled away from the active edge
    cnt = 0;
    @(negedge clk);
    while ((op == 1) ? !bvalid[p] : !rvalid[p]) begin
      if (cnt == TIMEOUT) begin
        report_timeout(p, (op == 1) ? "write response" : "read data");
        return;
      end
      @(negedge clk);
      cnt++;
    end
    if (op == 1) begin
      check_value($sformatf("bresp[%0d]", p), exp_resp, 32'(bresp[p]), ok);
    end else begin
      check_value($sformatf("rdata[%0d]", p), exp_data, 32'(rdata[p]), ok);
      check_value($sformatf("rresp[%0d]", p), exp_resp, 32'(rresp[p]), ok);
    end

    // Response order follows grant order through the pipeline
    order.push_back(p);

    // Ready already high means the handshake is at the next edge
    if (op == 2) begin
      @(posedge clk);
      rready[p] <= 1'b0;
    end else begin
      delay = int'($urandom_range(3, 0));
      repeat (delay) @(posedge clk);
      @(posedge clk);
      if (op == 1) begin
        bready[p] <= 1'b1;
      end else begin
        rready[p] <= 1'b1;
      end
      @(posedge clk);
      bready[p] <= 1'b0;
      rready[p] <= 1'b0;
    end

    tests++;
    if (!ok) begin
      failed_tests++;
    end
    $display("test %0d: batch %0d port %0d %s addr 0x%h %s", n, batch, p,
             (op == 1) ? "write" : "read", addr, ok ? "pass" : "fail");
  endtask

  // Lines of one batch for one port in file order
  task automatic run_port(input int p, input int b);
    for (int n = 0; n < num_lines; n++) begin
      if (!timed_out && pat[n*FIELDS] == b && pat[n*FIELDS+1] == p) begin
        run_transaction(p, n);
      end
    end
  endtask

  // Ports that start together are served in cyclic order after the last winner
  // No port may see a second response while another still waits for its first
  task automatic check_fairness(input int b);
    int seen [`NUM_PORTS];
    bit active [`NUM_PORTS];
    int expected [$];
    int first [$];
    int p;
    int actual;
    bit ok;
    ok = 1'b1;
    foreach (seen[i]) begin
      seen[i]   = 0;
      active[i] = 1'b0;
    end
    for (int n = 0; n < num_lines; n++) begin
      if (pat[n*FIELDS] == b) begin
        active[int'(pat[n*FIELDS+1])] = 1'b1;
      end
    end
    for (int k = 1; k <= `NUM_PORTS; k++) begin
      p = (last_winner + k) % `NUM_PORTS;
      if (active[p]) begin
        expected.push_back(p);
      end
    end
    foreach (order[k]) begin
      seen[order[k]]++;
      if (seen[order[k]] == 1) begin
        first.push_back(order[k]);
      end else if (seen[order[k]] == 2) begin
        for (int q = 0; q < `NUM_PORTS; q++) begin
          if (active[q] && seen[q] == 0) begin
            $display("Port %0d got a second response before port %0d got its first",
                     order[k], q);
            errors++;
            ok = 1'b0;
          end
        end
      end
    end
    // First response of each port shows the order of the first grants
    foreach (expected[k]) begin
      actual = (k < first.size()) ? first[k] : -1;
      check_value($sformatf("grant order[%0d]", k), 32'(expected[k]), 32'(actual), ok);
    end
    tests++;
    if (!ok) begin
      failed_tests++;
    end
    $display("test order: batch %0d %s", b, ok ? "pass" : "fail");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int last_batch;
    void'($urandom(32'h784344c8));
    rst          = 1'b1;
    awvalid      = '0;
    awaddr       = '0;
    wvalid       = '0;
    wdata        = '0;
    wstrb        = '0;
    bready       = '0;
    arvalid      = '0;
    araddr       = '0;
    rready       = '0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    // Priority starts at port 0
    last_winner  = `NUM_PORTS - 1;
    // All ones marks the end of the pattern lines
    foreach (pat[i]) begin
      pat[i] = '1;
    end
    $readmemh("tb/axil_shared_regs_patterns.txt", pat);
    num_lines  = 0;
    last_batch = 0;
    while (num_lines < MAX_LINES && pat[num_lines*FIELDS] !== '1) begin
      if (int'(pat[num_lines*FIELDS]) > last_batch) begin
        last_batch = int'(pat[num_lines*FIELDS]);
      end
      num_lines++;
    end

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Ports of one batch start together
    for (int b = 0; b <= last_batch; b++) begin
      if (timed_out) begin
        break;
      end
      order.delete();
      fork
        run_port(0, b);
        run_port(1, b);
        run_port(2, b);
        run_port(3, b);
      join
      if (!timed_out && order.size() > 0) begin
        check_fairness(b);
        last_winner = order[$];
      end
    end

    repeat (2) @(posedge clk);
    $display("Summary: %0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_axil_shared_regs
